// File: soc_top.f
logic/soc_pkg.sv
logic/soc_bus_dec.sv
logic/soc_mem.sv
logic/soc_gpio.sv
logic/soc_top.sv
bench/soc_top_checker.sv
bench/soc_top_tb.sv

// File: Bender.yml
package:
  name: soc_top

sources:
  # design, package first
  - logic/soc_pkg.sv
  - logic/soc_bus_dec.sv
  - logic/soc_mem.sv
  - logic/soc_gpio.sv
  - logic/soc_top.sv
  # simulation only
  - target: test
    files:
      - bench/soc_top_checker.sv
      - bench/soc_top_tb.sv

// File: bench/soc_top_tb.sv
// testbench for soc_top that checks random load/store traffic from an LFSR against a reference model
`timescale 1ns/1ps

module soc_top_tb import soc_pkg::*; ();

localparam int unsigned mem_aw     = soc_aw-3;  // 2048 words
localparam int unsigned gw         = 32;
localparam int unsigned pool_n     = 16;        // words used by the memory tests
localparam int unsigned max_cycles = 3000;      // watchdog limit

logic          clk = 1'b0;
logic          rst_n;
bus_req_t      req;
bus_rsp_t      rsp;
logic [gw-1:0] gpio_o;
logic [gw-1:0] gpio_e;
logic [gw-1:0] gpio_i;

// reference model state
logic [soc_dw-1:0] mem_model [0:2**mem_aw-1];
logic [gw-1:0]     out_model;
logic [gw-1:0]     oen_model;
logic [gw-1:0]     sync_m;          // input synchroniser pipe
logic [gw-1:0]     sync_s;
logic [gw-1:0]     pins_drv;        // next value for gpio_i
logic [mem_aw-1:0] pool [0:pool_n-1];
bus_rsp_t          exp_q [$];       // expected responses due next cycle

logic [31:0] lfsr = 32'h2502;
int          err_cnt;
int          check_cnt;
int          tests_run;
int          tests_failed;
int          test_err0;
string       cur_test;

always #50 clk = ~clk;  // 100 ns period

soc_top #(
  .mem_aw (mem_aw),
  .gw     (gw)
) soc_top_inst (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (req),
  .rsp    (rsp),
  .gpio_o (gpio_o),
  .gpio_e (gpio_e),
  .gpio_i (gpio_i)
);

////////////////////////////////////////////////////////////
// random numbers
////////////////////////////////////////////////////////////

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  if (s[0]) return (s >> 1) ^ 32'h8020_0003;  // x^32+x^22+x^2+x+1
  return s >> 1;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    lfsr = lfsr_step(lfsr);
    v = {v[30:0], lfsr[0]};  // one step per bit
  end
  return v;
endfunction

////////////////////////////////////////////////////////////
// request builders and model
////////////////////////////////////////////////////////////

function automatic logic [31:0] byte_merge(input logic [31:0] old, input logic [31:0] wdt,
                                           input logic [3:0] ben);
  logic [31:0] m;
  m = old;
  for (int b = 0; b < 4; b++) begin
    if (ben[b]) m[8*b +: 8] = wdt[8*b +: 8];
  end
  return m;
endfunction

// memory access with random ben, wdt and low address bits
function automatic bus_req_t mem_acc(input logic wen, input logic [mem_aw-1:0] widx);
  bus_req_t    r;
  logic [31:0] x;
  x = rand_bits(6);
  r.vld = 1'b1;
  r.wen = wen;
  r.adr = {1'b0, widx, x[1:0]};
  r.ben = x[5:2];
  r.wdt = rand_bits(32);
  return r;
endfunction

// GPIO access with random upper window bits so the aliases get hit
function automatic bus_req_t gpio_acc(input logic wen, input logic [1:0] off);
  bus_req_t    r;
  logic [31:0] x;
  x = rand_bits(15);
  r.vld = 1'b1;
  r.wen = wen;
  r.adr = {1'b1, x[10:2], off, x[1:0]};
  r.ben = x[14:11];
  r.wdt = rand_bits(32);
  return r;
endfunction

// updates the model and returns the response due for a request at the coming edge
function automatic bus_rsp_t model_access(input bus_req_t r);
  bus_rsp_t          e;
  logic [mem_aw-1:0] widx;
  e = '0;
  if (!r.vld) return e;
  e.vld = 1'b1;
  if (r.adr[soc_aw-1] == 1'b0) begin
    widx = r.adr[mem_aw+1:2];
    if (r.wen) mem_model[widx] = byte_merge(mem_model[widx], r.wdt, r.ben);
    else e.rdt = mem_model[widx];  // full word whatever ben says
  end else if (r.wen) begin
    case (gpio_reg_e'(r.adr[3:2]))
      gpio_out: out_model = byte_merge(out_model, r.wdt, r.ben);
      gpio_oen: oen_model = byte_merge(oen_model, r.wdt, r.ben);
      default:  ;  // read only or reserved
    endcase
  end else begin
    case (gpio_reg_e'(r.adr[3:2]))
      gpio_out: e.rdt = out_model;
      gpio_oen: e.rdt = oen_model;
      gpio_in:  e.rdt = sync_s;
      default:  e.rdt = '0;
    endcase
  end
  return e;
endfunction

////////////////////////////////////////////////////////////
// checks and cycle driver
////////////////////////////////////////////////////////////

task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
  check_cnt++;
  assert (act === exp) else begin
    $display("Mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
    err_cnt++;
  end
endtask

task automatic check_outputs();
  bus_rsp_t e;
  if (exp_q.size() > 0) begin
    e = exp_q.pop_front();
    check_val("rsp.vld", 32'(e.vld), 32'(rsp.vld));
    if (e.vld) check_val("rsp.rdt", e.rdt, rsp.rdt);
  end
  check_val("gpio_o", out_model, gpio_o);  // pins follow the write edge
  check_val("gpio_e", oen_model, gpio_e);
endtask

// checks the last response on the falling edge and drives the next request
task automatic do_cycle(input bus_req_t r);
  @(negedge clk);
  check_outputs();
  req    = r;
  gpio_i = pins_drv;
  exp_q.push_back(model_access(r));
  sync_s = sync_m;  // coming edge shifts the synchroniser
  sync_m = pins_drv;
endtask

task automatic start_test(input string name);
  cur_test  = name;
  test_err0 = err_cnt;
endtask

task automatic end_test();
  int n;
  do_cycle('0);  // collect the last response inside this test
  n = err_cnt - test_err0;
  tests_run++;
  if (n == 0) begin
    $display("[%s] ok", cur_test);
  end else begin
    tests_failed++;
    $display("[%s] FAIL, %0d errors", cur_test, n);
  end
endtask

////////////////////////////////////////////////////////////
// tests
////////////////////////////////////////////////////////////

initial begin
  bus_req_t    r;
  logic [31:0] x;
  logic        seen;
  req = '0;
  gpio_i = '0;
  rst_n = 1'b0;
  pins_drv = '0;
  out_model = '0;
  oen_model = '0;
  sync_m = '0;
  sync_s = '0;
  err_cnt = 0;
  check_cnt = 0;
  tests_run = 0;
  tests_failed = 0;
  repeat (2) @(posedge clk);
  @(negedge clk);
  rst_n = 1'b1;

  start_test("reset");
  check_val("gpio_o", '0, gpio_o);
  check_val("gpio_e", '0, gpio_e);
  check_val("rsp.vld", '0, 32'(rsp.vld));
  do_cycle(gpio_acc(1'b0, gpio_out));
  do_cycle(gpio_acc(1'b0, gpio_oen));
  end_test();

  start_test("mem_bytes");
  for (int i = 0; i < pool_n; i++) begin
    x = rand_bits(mem_aw);
    pool[i] = x[mem_aw-1:0];
    r = mem_acc(1'b1, pool[i]);
    r.ben = 4'hf;  // full word first so the model starts with known data
    do_cycle(r);
  end
  for (int i = 0; i < 60; i++) begin
    x = rand_bits(5);
    do_cycle(mem_acc(x[4], pool[x[3:0]]));
  end
  for (int i = 0; i < pool_n; i++) do_cycle(mem_acc(1'b0, pool[i]));
  end_test();

  start_test("read_first");
  for (int i = 0; i < 10; i++) begin
    x = rand_bits(4);
    do_cycle(mem_acc(1'b0, pool[x[3:0]]));  // old word
    r = mem_acc(1'b1, pool[x[3:0]]);
    r.ben = r.ben | 4'b0001;
    do_cycle(r);
    do_cycle(mem_acc(1'b0, pool[x[3:0]]));  // new word in the next cycle
  end
  end_test();

  start_test("gpio_regs");
  for (int i = 0; i < 40; i++) begin
    x = rand_bits(3);
    do_cycle(gpio_acc(x[2], x[1:0]));
  end
  do_cycle(gpio_acc(1'b1, gpio_in));  // must be ignored
  do_cycle(gpio_acc(1'b1, gpio_rsv));
  do_cycle(gpio_acc(1'b0, gpio_rsv));
  do_cycle(gpio_acc(1'b0, gpio_out));
  do_cycle(gpio_acc(1'b0, gpio_oen));
  end_test();

  start_test("gpio_sync");
  for (int i = 0; i < 8; i++) begin
    x = rand_bits(gw);
    pins_drv = x[gw-1:0];
    seen = 1'b0;
    for (int t = 0; t < 8 && !seen; t++) begin
      do_cycle(gpio_acc(1'b0, gpio_in));
      if (t > 0 && rsp.vld && rsp.rdt[gw-1:0] == pins_drv) seen = 1'b1;
    end
    assert (seen) else begin
      $display("timeout in %s: gpio_in reads never returned pins %h", cur_test, pins_drv);
      err_cnt++;
    end
  end
  end_test();

  start_test("mixed");
  for (int i = 0; i < 200; i++) begin
    x = rand_bits(12);
    if (x[8:7] == 2'b11) begin
      pins_drv = rand_bits(gw);
    end
    if (x[11:9] == 3'd0) r = '0;  // idle slot now and then
    else if (x[6]) r = gpio_acc(x[5], x[1:0]);
    else r = mem_acc(x[5], pool[x[4:1]]);
    do_cycle(r);
  end
  end_test();

  for (int i = 0; i < 4 && exp_q.size() > 0; i++) begin
    @(negedge clk);
    check_outputs();
  end
  $display("summary: %0d tests, %0d failing, %0d checks, %0d errors, %0d assertion failures",
           tests_run, tests_failed, check_cnt, err_cnt, soc_top_inst.soc_top_chk.fail_cnt);
  if (err_cnt == 0 && tests_failed == 0 && soc_top_inst.soc_top_chk.fail_cnt == 0) begin
    $display("test passed");
  end else begin
    $display("test failed");
  end
  $finish;
end

// watchdog that ends a stuck run
initial begin
  for (int c = 0; c < max_cycles; c++) @(posedge clk);
  $display("timeout: run did not finish within %0d cycles", max_cycles);
  $display("test failed");
  $finish;
end

endmodule: soc_top_tb

// File: bench/soc_top_checker.sv
// concurrent assertions on soc_top bus timing and reset state, attached to every soc_top by bind
`timescale 1ns/1ps

module soc_top_checker import soc_pkg::*; #(
  int unsigned gw = 32  // GPIO pins
)(
  input logic          clk,
  input logic          rst_n,
  input bus_req_t      req,
  input bus_rsp_t      rsp,
  input logic [gw-1:0] gpio_o,
  input logic [gw-1:0] gpio_e
);

int unsigned fail_cnt = 0;  // failed assertions, summed up by the testbench

////////////////////////////////////////////////////////////
// bus timing
////////////////////////////////////////////////////////////

// one response per request, exactly one cycle later
a_rsp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
  1'b1 |=> (rsp.vld == $past(req.vld)))
  else begin
    $error("rsp.vld does not follow req.vld by one cycle");
    fail_cnt++;
  end

// read data must be driven whenever a response is present
a_rdt_known: assert property (@(posedge clk) disable iff (!rst_n)
  rsp.vld |-> !$isunknown(rsp.rdt))
  else begin
    $error("rsp.rdt has unknown bits on a valid response");
    fail_cnt++;
  end

a_wr_rdt_zero: assert property (@(posedge clk) disable iff (!rst_n)
  (req.vld && req.wen) |=> (rsp.rdt == '0))  // write answers carry no data
  else begin
    $error("rsp.rdt is not zero on a write response");
    fail_cnt++;
  end

////////////////////////////////////////////////////////////
// reset state
////////////////////////////////////////////////////////////

a_reset_pins: assert property (@(posedge clk)
  !rst_n |=> (gpio_o == '0 && gpio_e == '0))  // pins held at zero through reset
  else begin
    $error("gpio_o or gpio_e not zero during reset");
    fail_cnt++;
  end

endmodule: soc_top_checker

bind soc_top soc_top_checker #(.gw(gw)) soc_top_chk (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (req),
  .rsp    (rsp),
  .gpio_o (gpio_o),
  .gpio_e (gpio_e)
);

// File: logic/soc_top.sv
// top level of the SoC data side, external load/store port feeding data memory and GPIO
`timescale 1ns/1ps

module soc_top import soc_pkg::*; #(
  int unsigned mem_aw = soc_aw-3,  // lower half as words, 2048
  int unsigned gw     = 32         // GPIO pins
)(
  // system signals
  input  logic          clk,
  input  logic          rst_n,
  // load/store port from the core
  input  bus_req_t      req,
  output bus_rsp_t      rsp,
  // GPIO pins
  output logic [gw-1:0] gpio_o,
  output logic [gw-1:0] gpio_e,
  input  logic [gw-1:0] gpio_i
);

////////////////////////////////////////////////////////////
// local signals
////////////////////////////////////////////////////////////

bus_req_t mem_req;   // decoder to data memory
bus_rsp_t mem_rsp;
bus_req_t gpio_req;  // decoder to GPIO
bus_rsp_t gpio_rsp;

////////////////////////////////////////////////////////////
// load/store decoder
////////////////////////////////////////////////////////////

soc_bus_dec ls_dec (
  .clk      (clk),
  .rst_n    (rst_n),
  .req      (req),
  .rsp      (rsp),
  .mem_req  (mem_req),
  .mem_rsp  (mem_rsp),
  .gpio_req (gpio_req),
  .gpio_rsp (gpio_rsp)
);

////////////////////////////////////////////////////////////
// data memory
////////////////////////////////////////////////////////////

soc_mem #(
  .mem_aw (mem_aw)
) data_mem (
  .clk   (clk),
  .rst_n (rst_n),
  .req   (mem_req),
  .rsp   (mem_rsp)
);

////////////////////////////////////////////////////////////
// GPIO
////////////////////////////////////////////////////////////

soc_gpio #(
  .gw (gw)
) gpio_ctl (
  .clk    (clk),
  .rst_n  (rst_n),
  .req    (gpio_req),
  .rsp    (gpio_rsp),
  .gpio_o (gpio_o),
  .gpio_e (gpio_e),
  .gpio_i (gpio_i)
);

endmodule: soc_top

// File: logic/soc_gpio.sv
// GPIO controller on the load/store bus, output/enable registers and a synchronised input register
`timescale 1ns/1ps

module soc_gpio import soc_pkg::*; #(
  int unsigned gw = 32  // number of pins, 1 to 32
)(
  // system signals
  input  logic          clk,
  input  logic          rst_n,
  // load/store bus
  input  bus_req_t      req,
  output bus_rsp_t      rsp,
  // pins
  output logic [gw-1:0] gpio_o,  // output values
  output logic [gw-1:0] gpio_e,  // output enables
  input  logic [gw-1:0] gpio_i   // raw pin inputs
);

////////////////////////////////////////////////////////////
// local signals
////////////////////////////////////////////////////////////

gpio_reg_e         reg_sel;  // addressed register
logic              wr;       // write request
logic              rd;       // read request

logic [gw-1:0]     gpio_m;   // first sync stage, may go metastable
logic [gw-1:0]     gpio_s;   // second sync stage, safe to read

logic [soc_dw-1:0] rd_word;  // selected register, zero-extended

logic              rsp_vld;
logic [soc_dw-1:0] rsp_rdt;

// offset from bits [3:2], higher bits ignored so the block repeats
assign reg_sel = gpio_reg_e'(req.adr[3:2]);
assign wr      = req.vld &  req.wen;
assign rd      = req.vld & ~req.wen;

////////////////////////////////////////////////////////////
// register writes
////////////////////////////////////////////////////////////

// pins change right after the request edge
always_ff @(posedge clk or negedge rst_n) begin
  if (!rst_n) begin
    gpio_o <= '0;
    gpio_e <= '0;  // all pins start as inputs
  end else if (wr) begin
    case (reg_sel)
      gpio_out: begin
        for (int i = 0; i < gw; i++) begin
          if (req.ben[i/8]) begin
            gpio_o[i] <= req.wdt[i];  // lane of bit i
          end
        end
      end
      gpio_oen: begin
        for (int i = 0; i < gw; i++) begin
          if (req.ben[i/8]) begin
            gpio_e[i] <= req.wdt[i];
          end
        end
      end
      default: begin
        // gpio_in and gpio_rsv are not writable
      end
    endcase
  end
end

////////////////////////////////////////////////////////////
// input synchroniser
////////////////////////////////////////////////////////////

// pins are asynchronous to clk, two flops before use
always_ff @(posedge clk or negedge rst_n) begin
  if (!rst_n) begin
    gpio_m <= '0;
    gpio_s <= '0;
  end else begin
    gpio_m <= gpio_i;
    gpio_s <= gpio_m;
  end
end

////////////////////////////////////////////////////////////
// register reads
////////////////////////////////////////////////////////////

always_comb begin
  rd_word = '0;  // upper bits stay zero for gw < 32
  case (reg_sel)
    gpio_out: rd_word[gw-1:0] = gpio_o;
    gpio_oen: rd_word[gw-1:0] = gpio_e;
    gpio_in:  rd_word[gw-1:0] = gpio_s;
    default:  rd_word = '0;  // reserved
  endcase
end

// read data registered, writes answer with zero
always_ff @(posedge clk) begin
  if (rd) begin
    rsp_rdt <= rd_word;
  end else if (wr) begin
    rsp_rdt <= '0;
  end
end

// one response per request, one cycle later
always_ff @(posedge clk or negedge rst_n) begin
  if (!rst_n) begin
    rsp_vld <= 1'b0;
  end else begin
    rsp_vld <= req.vld;
  end
end

assign rsp.vld = rsp_vld;
assign rsp.rdt = rsp_rdt;

endmodule: soc_gpio

// File: logic/soc_mem.sv
// word-organised data RAM on the load/store bus, byte write enables, read-first, one cycle latency
`timescale 1ns/1ps

module soc_mem import soc_pkg::*; #(
  int unsigned mem_aw = 11  // word address width
)(
  // system signals
  input  logic     clk,
  input  logic     rst_n,
  // load/store bus
  input  bus_req_t req,
  output bus_rsp_t rsp
);

////////////////////////////////////////////////////////////
// local signals
////////////////////////////////////////////////////////////

localparam int unsigned mem_dp = 2**mem_aw;  // depth in words

logic [soc_dw-1:0] mem [0:mem_dp-1];  // storage, not reset

logic [mem_aw-1:0] idx;  // word index
logic              wr;   // write request
logic              rd;   // read request

logic              rsp_vld;
logic [soc_dw-1:0] rsp_rdt;

// byte address to word index, lower two bits drop out
assign idx = req.adr[mem_aw+1:2];
assign wr  = req.vld &  req.wen;
assign rd  = req.vld & ~req.wen;

////////////////////////////////////////////////////////////
// write
////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
  if (wr) begin
    for (int b = 0; b < soc_bw; b++) begin
      if (req.ben[b]) begin
        mem[idx][8*b +: 8] <= req.wdt[8*b +: 8];  // enabled lanes only
      end
    end
  end
end

////////////////////////////////////////////////////////////
// read and response
////////////////////////////////////////////////////////////

// old word is registered, full word regardless of ben
always_ff @(posedge clk) begin
  if (rd) begin
    rsp_rdt <= mem[idx];
  end else if (wr) begin
    rsp_rdt <= '0;  // write responses carry no data
  end
end

// every taken request gets a response next cycle
always_ff @(posedge clk or negedge rst_n) begin
  if (!rst_n) begin
    rsp_vld <= 1'b0;
  end else begin
    rsp_vld <= req.vld;
  end
end

assign rsp.vld = rsp_vld;
assign rsp.rdt = rsp_rdt;

endmodule: soc_mem

// File: logic/soc_bus_dec.sv
// load/store address decoder, sends each request to data memory or GPIO and returns the response
`timescale 1ns/1ps

module soc_bus_dec import soc_pkg::*; (
  // system signals
  input  logic     clk,
  input  logic     rst_n,
  // master side
  input  bus_req_t req,
  output bus_rsp_t rsp,
  // data memory side
  output bus_req_t mem_req,
  input  bus_rsp_t mem_rsp,
  // GPIO side
  output bus_req_t gpio_req,
  input  bus_rsp_t gpio_rsp
);

////////////////////////////////////////////////////////////
// local signals
////////////////////////////////////////////////////////////

logic sel;    // slave addressed by the current request
logic sel_q;  // slave that took the previous request

////////////////////////////////////////////////////////////
// request path
////////////////////////////////////////////////////////////

// top address bit picks the half
assign sel = req.adr[soc_sel_bit];

// all fields go to both slaves, only vld is steered
always_comb begin
  mem_req      = req;
  mem_req.vld  = req.vld & (sel == slv_mem);
  gpio_req     = req;
  gpio_req.vld = req.vld & (sel == slv_gpio);
end

////////////////////////////////////////////////////////////
// response path
////////////////////////////////////////////////////////////

// remember who owns the response due next cycle
// only updated when a request is taken
always_ff @(posedge clk or negedge rst_n) begin
  if (!rst_n) begin
    sel_q <= slv_mem;  // memory after reset
  end else if (req.vld) begin
    sel_q <= sel;
  end
end

// the idle slave holds its vld low, so muxing on sel_q is enough
// this keeps alternating mem/GPIO traffic in order
always_comb begin
  case (sel_q)
    slv_gpio: rsp = gpio_rsp;
    default:  rsp = mem_rsp;
  endcase
end

endmodule: soc_bus_dec

// File: logic/soc_pkg.sv
// shared widths, address map and bus types for the load/store side of the SoC, import with soc_pkg::*
package soc_pkg;

////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////

localparam int unsigned soc_aw = 14;         // byte address width, 16kB space
localparam int unsigned soc_dw = 32;         // data width
localparam int unsigned soc_bw = soc_dw/8;   // byte enables, one per byte lane

////////////////////////////////////////////////////////////
// address map
////////////////////////////////////////////////////////////

// the space is split in half by the top address bit
localparam int unsigned soc_sel_bit = soc_aw-1;

localparam logic slv_mem  = 1'b0;  // 0x0000 ~ 0x1fff data memory
localparam logic slv_gpio = 1'b1;  // 0x2000 ~ 0x3fff GPIO window

////////////////////////////////////////////////////////////
// load/store bus
////////////////////////////////////////////////////////////

// request, sampled on every clk edge with vld high
// no ready, slaves never stall
typedef struct packed {
  logic              vld;  // request present
  logic              wen;  // write enable
  logic [soc_aw-1:0] adr;  // byte address
  logic [soc_bw-1:0] ben;  // byte enables, writes only
  logic [soc_dw-1:0] wdt;  // write data
} bus_req_t;

// response, one cycle after the request
typedef struct packed {
  logic              vld;  // response present
  logic [soc_dw-1:0] rdt;  // read data, zero on writes
} bus_rsp_t;

////////////////////////////////////////////////////////////
// GPIO registers
////////////////////////////////////////////////////////////

// word offset inside the GPIO window, address bits [3:2]
// registers repeat through the rest of the window
typedef enum logic [1:0] {
  gpio_out = 2'd0,  // output values
  gpio_oen = 2'd1,  // output enables
  gpio_in  = 2'd2,  // synchronised inputs, read only
  gpio_rsv = 2'd3   // reserved, reads zero
} gpio_reg_e;

endpackage: soc_pkg
